//--- stage_pkg.sv
`default_nettype none

package stage_pkg;

    localparam int NUM_QUEUES    = 4;
    localparam int TABLE_DEPTH   = 8;
    localparam int QUEUE_CREDITS = 4;
    localparam int TABLE_IDX_W   = $clog2(TABLE_DEPTH);
    localparam int CREDIT_W      = $clog2(QUEUE_CREDITS + 1);

    // field order from msb down
    typedef struct packed {
        logic [15:0]           dst_port;
        logic [15:0]           src_port;
        logic [31:0]           dst_ip;
        logic [31:0]           src_ip;
        logic [11:0]           vlan;
        logic [NUM_QUEUES-1:0] queue_map;
        logic [15:0]           meta;
    } phv_t;

    typedef struct packed {
        logic [31:0] dst_ip;
        logic [15:0] dst_port;
    } key_t;

    typedef enum logic [1:0] {
        OP_NOP      = 2'd0,
        OP_SET_VLAN = 2'd1,
        OP_ADD_META = 2'd2,
        OP_DROP     = 2'd3
    } act_op_t;

    typedef struct packed {
        act_op_t               op;
        logic [NUM_QUEUES-1:0] queue_map;
        logic [15:0]           operand;
    } action_t;

    typedef struct packed {
        logic                   wr_en;
        logic [TABLE_IDX_W-1:0] index;
        logic                   entry_valid;
        key_t                   key;
        action_t                action;
    } cfg_t;

    typedef struct packed {
        logic valid;
        key_t key;
        phv_t phv;
    } keyed_phv_t;

    typedef struct packed {
        logic    valid;
        action_t action;
        phv_t    phv;
    } acted_phv_t;

    // miss goes to queue 0 untouched
    localparam action_t DEFAULT_ACTION = '{op: OP_NOP, queue_map: 4'b0001, operand: 16'h0000};

endpackage

`default_nettype wire

//--- key_extract.sv
`timescale 1ns/1ps
`default_nettype none

module key_extract (
    input  wire                    axis_clk,
    input  wire                    aresetn,
    input  wire stage_pkg::phv_t   phv_in,
    input  wire                    phv_in_valid,
    input  wire                    advance,
    output stage_pkg::keyed_phv_t  key_out
);

    import stage_pkg::*;

    logic valid_q;
    key_t key_q;
    phv_t phv_q;
    key_t key_next;

    // exact key is dst_ip then dst_port
    always_comb begin
        key_next.dst_ip   = phv_in.dst_ip;
        key_next.dst_port = phv_in.dst_port;
    end

    always_ff @(posedge axis_clk) begin
        if (!aresetn) begin
            valid_q <= 1'b0;
        end else if (advance) begin
            valid_q <= phv_in_valid;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (advance) begin
            key_q <= key_next;
            phv_q <= phv_in;
        end
    end

    assign key_out = '{valid: valid_q, key: key_q, phv: phv_q};

endmodule

`default_nettype wire

//--- match_table.sv
`timescale 1ns/1ps
`default_nettype none

module match_table (
    input  wire                    axis_clk,
    input  wire                    aresetn,
    input  wire stage_pkg::cfg_t   cfg,
    input  wire stage_pkg::keyed_phv_t keyed_in,
    input  wire                    advance,
    output stage_pkg::acted_phv_t  acted_out
);

    import stage_pkg::*;

    logic [TABLE_DEPTH-1:0] entry_valid;
    key_t                   entry_key    [TABLE_DEPTH];
    action_t                entry_action [TABLE_DEPTH];

    action_t hit_action;
    logic    valid_q;
    action_t action_q;
    phv_t    phv_q;

    // entry valid bits are the only table state under reset
    always_ff @(posedge axis_clk) begin
        if (!aresetn) begin
            entry_valid <= '0;
        end else if (cfg.wr_en) begin
            entry_valid[cfg.index] <= cfg.entry_valid;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (cfg.wr_en) begin
            entry_key[cfg.index]    <= cfg.key;
            entry_action[cfg.index] <= cfg.action;
        end
    end

    // walk downward so the lowest hit index wins
    always_comb begin
        hit_action = DEFAULT_ACTION;
        for (int i = TABLE_DEPTH - 1; i >= 0; i--) begin
            if (entry_valid[i] && (entry_key[i] == keyed_in.key)) begin
                hit_action = entry_action[i];
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (!aresetn) begin
            valid_q <= 1'b0;
        end else if (advance) begin
            valid_q <= keyed_in.valid;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (advance) begin
            action_q <= hit_action;
            phv_q    <= keyed_in.phv;
        end
    end

    assign acted_out = '{valid: valid_q, action: action_q, phv: phv_q};

    a_cfg_index: assert property (@(posedge axis_clk) disable iff (!aresetn)
        cfg.wr_en |-> (int'(cfg.index) < TABLE_DEPTH))
        else $error("cfg write to index %0d beyond table", cfg.index);

endmodule

`default_nettype wire

//--- action_engine.sv
`timescale 1ns/1ps
`default_nettype none

module action_engine (
    input  wire                        axis_clk,
    input  wire                        aresetn,
    input  wire stage_pkg::acted_phv_t acted_in,
    input  wire                        advance,
    output stage_pkg::phv_t            phv_out,
    output logic                       phv_out_valid
);

    import stage_pkg::*;

    phv_t phv_next;
    phv_t phv_q;
    logic valid_q;

    always_comb begin
        phv_next = acted_in.phv;
        case (acted_in.action.op)
            OP_SET_VLAN: begin
                phv_next.vlan = acted_in.action.operand[11:0];
            end
            OP_ADD_META: begin
                // wraps at 16 bits
                phv_next.meta = acted_in.phv.meta + acted_in.action.operand;
            end
            default: begin
                phv_next.vlan = acted_in.phv.vlan;
            end
        endcase

        if (acted_in.action.op == OP_DROP) begin
            phv_next.queue_map = '0;
        end else begin
            phv_next.queue_map = acted_in.action.queue_map;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (!aresetn) begin
            valid_q <= 1'b0;
        end else if (advance) begin
            valid_q <= acted_in.valid;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (advance) begin
            phv_q <= phv_next;
        end
    end

    assign phv_out       = phv_q;
    assign phv_out_valid = valid_q;

    // payload regs have no reset, so an X here means a bubble got marked valid
    a_known_phv: assert property (@(posedge axis_clk) disable iff (!aresetn)
        phv_out_valid |-> !$isunknown(phv_out))
        else $error("valid phv with unknown bits at action output");

endmodule

`default_nettype wire

//--- credit_counter.sv
`timescale 1ns/1ps
`default_nettype none

module credit_counter (
    input  wire                               axis_clk,
    input  wire                               aresetn,
    input  wire  [stage_pkg::NUM_QUEUES-1:0]  credit_return,
    input  wire  [stage_pkg::NUM_QUEUES-1:0]  consume,
    output logic [stage_pkg::NUM_QUEUES-1:0]  has_credit
);

    import stage_pkg::*;

    logic [CREDIT_W-1:0] count [NUM_QUEUES];

    // return and consume may land on the same edge
    always_ff @(posedge axis_clk) begin
        if (!aresetn) begin
            for (int q = 0; q < NUM_QUEUES; q++) begin
                count[q] <= CREDIT_W'(QUEUE_CREDITS);
            end
        end else begin
            for (int q = 0; q < NUM_QUEUES; q++) begin
                count[q] <= count[q] + CREDIT_W'(credit_return[q])
                            - CREDIT_W'(consume[q]);
            end
        end
    end

    always_comb begin
        for (int q = 0; q < NUM_QUEUES; q++) begin
            has_credit[q] = (count[q] != '0);
        end
    end

    for (genvar g = 0; g < NUM_QUEUES; g++) begin : g_chk
        // a queue returning more than it was given
        a_no_overflow: assert property (@(posedge axis_clk) disable iff (!aresetn)
            int'(count[g]) <= QUEUE_CREDITS)
            else $error("queue %0d credit count above limit", g);

        a_no_underflow: assert property (@(posedge axis_clk) disable iff (!aresetn)
            consume[g] |-> (count[g] != '0))
            else $error("queue %0d consumed with no credit", g);
    end

endmodule

`default_nettype wire

//--- queue_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module queue_dispatch (
    input  wire                               axis_clk,
    input  wire                               aresetn,
    input  wire stage_pkg::phv_t              phv_in,
    input  wire                               phv_in_valid,
    output logic                              accept,
    input  wire  [stage_pkg::NUM_QUEUES-1:0]  has_credit,
    output logic [stage_pkg::NUM_QUEUES-1:0]  consume,
    output stage_pkg::phv_t                   q_phv,
    output logic [stage_pkg::NUM_QUEUES-1:0]  q_valid
);

    import stage_pkg::*;

    typedef enum logic {
        IDLE,
        HOLD
    } state_t;

    state_t state;
    logic   credit_ok;
    logic   emit;

    // an empty map passes trivially and retires silently
    assign credit_ok = ((q_phv.queue_map & ~has_credit) == '0);
    assign emit      = (state == HOLD) && credit_ok;
    assign accept    = (state == IDLE) || emit;
    assign q_valid   = emit ? q_phv.queue_map : '0;
    assign consume   = q_valid;

    always_ff @(posedge axis_clk) begin
        if (!aresetn) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (phv_in_valid) begin
                        state <= HOLD;
                    end
                end
                HOLD: begin
                    // back to back when the next phv is waiting
                    if (emit && !phv_in_valid) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge axis_clk) begin
        if (accept && phv_in_valid) begin
            q_phv <= phv_in;
        end
    end

    a_credit_gate: assert property (@(posedge axis_clk) disable iff (!aresetn)
        (q_valid & ~has_credit) == '0)
        else $error("q_valid %b sent without credit %b", q_valid, has_credit);

endmodule

`default_nettype wire

//--- last_stage.sv
`timescale 1ns/1ps
`default_nettype none

module last_stage (
    input  wire                               axis_clk,
    input  wire                               aresetn,
    input  wire stage_pkg::phv_t              phv_in,
    input  wire                               phv_in_valid,
    output logic                              stage_ready,
    input  wire stage_pkg::cfg_t              cfg,
    output stage_pkg::phv_t                   q_phv,
    output logic [stage_pkg::NUM_QUEUES-1:0]  q_valid,
    input  wire  [stage_pkg::NUM_QUEUES-1:0]  q_credit
);

    import stage_pkg::*;

    keyed_phv_t keyed;
    acted_phv_t acted;
    phv_t       ae_phv;
    logic       ae_valid;
    logic       disp_accept;

    logic [NUM_QUEUES-1:0] has_credit;
    logic [NUM_QUEUES-1:0] consume;

    logic ke_adv;
    logic mt_adv;
    logic ae_adv;

    // ready chain, a slot moves when the next one is empty or moving
    assign ae_adv      = !ae_valid || disp_accept;
    assign mt_adv      = !acted.valid || ae_adv;
    assign ke_adv      = !keyed.valid || mt_adv;
    assign stage_ready = ke_adv;

    key_extract u_key_extract (
        .axis_clk     (axis_clk),
        .aresetn      (aresetn),
        .phv_in       (phv_in),
        .phv_in_valid (phv_in_valid),
        .advance      (ke_adv),
        .key_out      (keyed)
    );

    match_table u_match_table (
        .axis_clk  (axis_clk),
        .aresetn   (aresetn),
        .cfg       (cfg),
        .keyed_in  (keyed),
        .advance   (mt_adv),
        .acted_out (acted)
    );

    action_engine u_action_engine (
        .axis_clk      (axis_clk),
        .aresetn       (aresetn),
        .acted_in      (acted),
        .advance       (ae_adv),
        .phv_out       (ae_phv),
        .phv_out_valid (ae_valid)
    );

    credit_counter u_credit_counter (
        .axis_clk      (axis_clk),
        .aresetn       (aresetn),
        .credit_return (q_credit),
        .consume       (consume),
        .has_credit    (has_credit)
    );

    queue_dispatch u_queue_dispatch (
        .axis_clk     (axis_clk),
        .aresetn      (aresetn),
        .phv_in       (ae_phv),
        .phv_in_valid (ae_valid),
        .accept       (disp_accept),
        .has_credit   (has_credit),
        .consume      (consume),
        .q_phv        (q_phv),
        .q_valid      (q_valid)
    );

endmodule

`default_nettype wire

//--- tb_last_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_last_stage;

    import stage_pkg::*;

    localparam int N_PHVS         = 54;
    localparam int TIMEOUT_CYCLES = 40 * N_PHVS + 200;

    logic                  axis_clk;
    logic                  aresetn;
    phv_t                  phv_in;
    logic                  phv_in_valid;
    logic                  stage_ready;
    cfg_t                  cfg;
    phv_t                  q_phv;
    logic [NUM_QUEUES-1:0] q_valid;
    logic [NUM_QUEUES-1:0] q_credit;

    int   stim_seed   = 32'h80ab_0b33;
    int   credit_seed = 32'h80ab_0b33;
    int   cycles      = 0;
    logic hold_credits;
    logic after_reset;
    key_t keys [4];

    // table model kept in step with every cfg write
    logic [TABLE_DEPTH-1:0] tbl_valid;
    key_t                   tbl_key [TABLE_DEPTH];
    action_t                tbl_act [TABLE_DEPTH];

    phv_t                  exp_q    [NUM_QUEUES][$];
    phv_t                  exp_head [NUM_QUEUES];
    phv_t                  seen_phv;
    logic [NUM_QUEUES-1:0] head_ok;
    int                    rd_idx   [NUM_QUEUES];
    int                    got      [NUM_QUEUES];
    int                    returned [NUM_QUEUES];
    int                    wait_cnt [NUM_QUEUES];

    last_stage u_last_stage (
        .axis_clk     (axis_clk),
        .aresetn      (aresetn),
        .phv_in       (phv_in),
        .phv_in_valid (phv_in_valid),
        .stage_ready  (stage_ready),
        .cfg          (cfg),
        .q_phv        (q_phv),
        .q_valid      (q_valid),
        .q_credit     (q_credit)
    );

    initial begin
        axis_clk = 1'b0;
        forever #10 axis_clk = ~axis_clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge axis_clk) begin
        cycles <= cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            fail_now($sformatf("timeout: run still going after %0d cycles", cycles));
        end
    end

    // queue models look mid-cycle
    always @(negedge axis_clk) begin
        seen_phv <= q_phv;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            if (rd_idx[q] < exp_q[q].size()) begin
                exp_head[q] <= exp_q[q][rd_idx[q]];
                head_ok[q]  <= (exp_q[q][rd_idx[q]] == q_phv);
            end else begin
                exp_head[q] <= '0;
                head_ok[q]  <= 1'b0;
            end
            if (q_valid[q]) begin
                got[q]    <= got[q] + 1;
                rd_idx[q] <= rd_idx[q] + 1;
            end
        end
    end

    // one credit back per phv 0 to 7 cycles later
    initial begin
        q_credit = '0;
        forever begin
            @(posedge axis_clk);
            #2;
            for (int q = 0; q < NUM_QUEUES; q++) begin
                q_credit[q] = 1'b0;
                if (got[q] > returned[q] && !hold_credits) begin
                    if (wait_cnt[q] == 0) begin
                        q_credit[q] = 1'b1;
                        returned[q] = returned[q] + 1;
                        wait_cnt[q] = $unsigned($random(credit_seed)) % 8;
                    end else begin
                        wait_cnt[q] = wait_cnt[q] - 1;
                    end
                end
            end
        end
    end

    for (genvar g = 0; g < NUM_QUEUES; g++) begin : g_queue_chk
        a_queue_phv: assert property (@(posedge axis_clk) disable iff (!aresetn)
            q_valid[g] |-> head_ok[g])
            else fail_now($sformatf("FAILED at %0d ns: queue %0d got %h, expected %h",
                                    $time, g, seen_phv, exp_head[g]));

        a_queue_limit: assert property (@(posedge axis_clk) disable iff (!aresetn)
            (got[g] - returned[g]) <= QUEUE_CREDITS)
            else fail_now($sformatf("FAILED at %0d ns: queue %0d holds %0d phvs, limit %0d",
                                    $time, g, got[g] - returned[g], QUEUE_CREDITS));
    end

    a_reset_idle: assert property (@(posedge axis_clk) disable iff (!aresetn)
        after_reset |-> ((q_valid == '0) && stage_ready))
        else fail_now($sformatf("FAILED at %0d ns: q_valid %b stage_ready %b after reset",
                                $time, q_valid, stage_ready));

    task automatic write_entry(input logic [TABLE_IDX_W-1:0] idx, input logic valid,
                               input key_t k, input act_op_t op,
                               input logic [NUM_QUEUES-1:0] map, input logic [15:0] operand);
        cfg = '{wr_en: 1'b1, index: idx, entry_valid: valid, key: k,
                action: '{op: op, queue_map: map, operand: operand}};
        tbl_valid[idx] = valid;
        tbl_key[idx]   = k;
        tbl_act[idx]   = cfg.action;
        @(posedge axis_clk);
        #2;
        cfg.wr_en = 1'b0;
    endtask

    // sel 0 to 3 picks a known key and anything else misses
    function automatic phv_t make_phv(input int sel);
        phv_t p;
        p = {$random(stim_seed), $random(stim_seed), $random(stim_seed), $random(stim_seed)};
        if (sel < 4) begin
            p.dst_ip   = keys[sel].dst_ip;
            p.dst_port = keys[sel].dst_port;
        end
        return p;
    endfunction

    function automatic phv_t predict(input phv_t p);
        action_t a;
        phv_t    r;
        logic    hit;
        a   = '{op: OP_NOP, queue_map: 4'b0001, operand: 16'h0000};
        hit = 1'b0;
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            if (!hit && tbl_valid[i] && (tbl_key[i] == {p.dst_ip, p.dst_port})) begin
                a   = tbl_act[i];
                hit = 1'b1;
            end
        end
        r           = p;
        r.queue_map = a.queue_map;
        case (a.op)
            OP_SET_VLAN: r.vlan = a.operand[11:0];
            OP_ADD_META: r.meta = p.meta + a.operand;
            OP_DROP:     r.queue_map = '0;
            default:     r.meta = p.meta;
        endcase
        return r;
    endfunction

    task automatic send(input phv_t p);
        phv_t e;
        e = predict(p);
        for (int q = 0; q < NUM_QUEUES; q++) begin
            if (e.queue_map[q]) begin
                exp_q[q].push_back(e);
            end
        end
        phv_in       = p;
        phv_in_valid = 1'b1;
        @(negedge axis_clk);
        while (!stage_ready) begin
            @(negedge axis_clk);
        end
        @(posedge axis_clk);
        #2;
        phv_in_valid = 1'b0;
    endtask

    // ten quiet cycles with every credit home cover the pipe latency
    task automatic drain();
        int quiet;
        quiet = 0;
        while (quiet < 10) begin
            @(posedge axis_clk);
            quiet++;
            for (int q = 0; q < NUM_QUEUES; q++) begin
                if (got[q] != returned[q]) begin
                    quiet = 0;
                end
            end
        end
        #2;
    endtask

    initial begin
        int   waited;
        int   gap;
        int   left;
        phv_t p;
        aresetn      = 1'b0;
        phv_in       = '0;
        phv_in_valid = 1'b0;
        cfg          = '0;
        hold_credits = 1'b0;
        after_reset  = 1'b0;
        tbl_valid    = '0;
        keys[0]      = 48'h0a00_0001_0050;
        keys[1]      = 48'h0a00_0002_01bb;
        keys[2]      = 48'hc0a8_0a0a_0035;
        keys[3]      = 48'hac10_0001_1f90;
        repeat (10) @(posedge axis_clk);
        #2;
        aresetn     = 1'b1;
        after_reset = 1'b1;
        repeat (5) @(posedge axis_clk);
        #2;
        after_reset = 1'b0;

        // entry 3 shares the key of entry 0 and loses to it
        write_entry(3'd0, 1'b1, keys[0], OP_SET_VLAN, 4'b0110, 16'hf5a5);
        write_entry(3'd1, 1'b1, keys[1], OP_ADD_META, 4'b1000, 16'hfff0);
        write_entry(3'd2, 1'b1, keys[2], OP_DROP, 4'b1111, 16'h0000);
        write_entry(3'd3, 1'b1, keys[0], OP_NOP, 4'b1111, 16'h0000);
        write_entry(3'd4, 1'b1, keys[3], OP_NOP, 4'b1111, 16'h0000);

        repeat (6) send(make_phv(0));
        drain();

        repeat (4) send(make_phv(4));
        p      = make_phv(1);
        p.meta = 16'h0020;
        send(p);
        repeat (3) send(make_phv(1));
        drain();

        send(make_phv(2));
        send(make_phv(0));
        send(make_phv(2));
        send(make_phv(1));
        send(make_phv(4));
        send(make_phv(0));
        drain();

        // stall every queue until the pipe backs up
        hold_credits = 1'b1;
        repeat (8) send(make_phv(3));
        waited = 0;
        while (stage_ready) begin
            @(negedge axis_clk);
            waited++;
            if (waited > 20) begin
                fail_now("stage_ready stayed high with all credits withheld");
            end
        end
        @(posedge axis_clk);
        #2;
        hold_credits = 1'b0;
        drain();

        write_entry(3'd0, 1'b1, keys[0], OP_ADD_META, 4'b0001, 16'h0100);
        write_entry(3'd1, 1'b0, keys[1], OP_NOP, 4'b0000, 16'h0000);
        repeat (4) send(make_phv(0));
        repeat (2) send(make_phv(1));
        drain();

        repeat (20) begin
            gap = $unsigned($random(stim_seed)) % 3;
            repeat (gap) begin
                @(posedge axis_clk);
                #2;
            end
            send(make_phv($unsigned($random(stim_seed)) % 5));
        end
        drain();

        left = 0;
        for (int q = 0; q < NUM_QUEUES; q++) begin
            left += exp_q[q].size() - rd_idx[q];
        end
        if (left != 0) begin
            fail_now($sformatf("%0d expected phvs never reached their queues", left));
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- filelist.f
stage_pkg.sv
key_extract.sv
match_table.sv
action_engine.sv
credit_counter.sv
queue_dispatch.sv
last_stage.sv
tb_last_stage.sv

//--- run.sh
#!/bin/sh
# build and run the last_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_last_stage -f filelist.f \
    -o tb_last_stage_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_last_stage_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
